/* run_sim.sh */
#!/bin/sh
# Build and run the SMC testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module smc_tb -f tb.f

# Assertion failures are counted, so the run goes on to the summary
./obj_dir/Vsmc_tb +verilator+error+limit+1000 > sim.log 2>&1 || true

if grep -qF '*** PASSED ***' sim.log; then
   exit 0
else
   exit 1
fi

/* source/smc_access_fsm.sv */
// Host must hold req, write and sizes stable until ack; wait states fixed by WAIT_STATES
module smc_access_fsm
   import smc_size_pkg::*;
   import smc_state_pkg::*;
#(
   parameter int WAIT_STATES = 1    // Extra cycles per access in SMC_RW
)
(
   input  logic        sys_clk28,
   input  logic        n_sys_reset28,
   input  logic        req,
   input  logic        write,
   input  xfer_size_t  xfer_size,
   input  bus_size_t   bus_size,
   output logic        ack,
   output logic        valid_access,
   output logic        smc_done,
   output logic [1:0]  r_num_access,
   output smc_state_t  smc_nextstate,
   output logic        smc_n_we,
   output logic        capture
);

   // Wait counter width, at least one bit
   localparam int WCW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
   localparam logic [WCW-1:0] WAIT_LAST = WCW'(WAIT_STATES);

   smc_state_t      r_state;
   logic [WCW-1:0]  r_wait_cnt;     // Cycles spent in SMC_RW
   logic            last_wait;

   assign last_wait    = (r_wait_cnt == WAIT_LAST);
   assign valid_access = (r_state == SMC_LE);       // Single pulse per transfer
   assign smc_done     = (r_state == SMC_FLOAT);    // End of each access
   assign capture      = (r_state == SMC_RW) && last_wait;

   // ------------------------------
   // Next state
   // ------------------------------
   always_comb
   begin
      smc_nextstate = r_state;
      case (r_state)
         SMC_IDLE:
         begin
            if (req)
               smc_nextstate = SMC_LE;
         end
         SMC_LE:
            smc_nextstate = SMC_RW;
         SMC_RW:
         begin
            if (last_wait)
               smc_nextstate = SMC_FLOAT;
         end
         SMC_FLOAT:
         begin
            // Last access done when counter is empty
            if (r_num_access == 2'd0)
               smc_nextstate = SMC_ACK;
            else
               smc_nextstate = SMC_RW;
         end
         SMC_ACK:
         begin
            if (!req)                 // Back-pressure while req held
               smc_nextstate = SMC_IDLE;
         end
         default:
            smc_nextstate = SMC_IDLE;
      endcase
   end

   always_ff @(posedge sys_clk28 or negedge n_sys_reset28)
   begin
      if (!n_sys_reset28)
      begin
         r_state    <= SMC_IDLE;
         r_wait_cnt <= '0;
      end
      else
      begin
         r_state <= smc_nextstate;
         if ((r_state == SMC_RW) && !last_wait)
            r_wait_cnt <= r_wait_cnt + 1'b1;
         else
            r_wait_cnt <= '0;           // Fresh count for every access
      end
   end

   // ------------------------------
   // Access counter and strobes
   // ------------------------------
   always_ff @(posedge sys_clk28 or negedge n_sys_reset28)
   begin
      if (!n_sys_reset28)
      begin
         r_num_access <= 2'd0;
         smc_n_we     <= 1'b1;
         ack          <= 1'b0;
      end
      else
      begin
         if (valid_access)
            r_num_access <= num_access_f(xfer_size, bus_size);
         else if (smc_done && (r_num_access != 2'd0))
            r_num_access <= r_num_access - 2'd1;   // Count down per access
         smc_n_we <= !((smc_nextstate == SMC_RW) && write);
         ack      <= (smc_nextstate == SMC_ACK);   // Rises with entry to SMC_ACK
      end
   end

endmodule

/* source/smc_addr.sv */
// Single chip select, little-endian access order; xfer_size and bus_size held stable by host
module smc_addr
   import smc_size_pkg::*;
   import smc_state_pkg::*;
(
   input  logic        sys_clk28,
   input  logic        n_sys_reset28,
   input  logic        valid_access,
   input  logic [1:0]  r_num_access,
   input  xfer_size_t  xfer_size,
   input  bus_size_t   bus_size,
   input  logic        cs,
   input  logic [31:0] addr,
   input  logic        smc_done,
   input  smc_state_t  smc_nextstate,
   output logic [31:0] smc_addr,
   output logic [3:0]  smc_n_be,
   output logic        smc_n_cs,
   output logic [3:0]  n_be
);

   logic        r_cs;               // Stored chip select
   logic [1:0]  r_addr;             // Stored low address bits
   logic        v_cs;
   logic [1:0]  v_addr;

   // Low address bits of the access with k accesses still to follow
   function automatic logic [1:0] low_bits_f(xfer_size_t xs, bus_size_t bs,
                                             logic [1:0] a, logic [1:0] k);
      logic [1:0] lb;
      lb = a;
      case ({xs, bs})
         {XSIZ_32, BSIZ_32}: lb = 2'b00;
         {XSIZ_32, BSIZ_16}: lb = {k[0], 1'b0};     // 10 then 00
         {XSIZ_32, BSIZ_8}:  lb = k;                // 11 down to 00
         {XSIZ_16, BSIZ_8}:  lb = {a[1], k[0]};     // High byte first
         {XSIZ_16, BSIZ_16},
         {XSIZ_16, BSIZ_32}: lb = {a[1], 1'b0};
         default:            lb = a;                // Bytes keep their address
      endcase
      return lb;
   endfunction

   // ------------------------------
   // Store cs and low bits
   // ------------------------------
   always_ff @(posedge sys_clk28 or negedge n_sys_reset28)
   begin
      if (!n_sys_reset28)
      begin
         r_cs   <= 1'b0;
         r_addr <= 2'b00;
      end
      else if (valid_access)
      begin
         r_cs   <= cs;
         r_addr <= addr[1:0];
      end
   end

   // Live values during SMC_LE, stored ones afterwards
   assign v_cs   = valid_access ? cs : r_cs;
   assign v_addr = valid_access ? addr[1:0] : r_addr;

   // ------------------------------
   // External address
   // ------------------------------
   always_ff @(posedge sys_clk28 or negedge n_sys_reset28)
   begin
      if (!n_sys_reset28)
         smc_addr <= 32'h0;
      else if (valid_access)
         smc_addr <= {addr[31:2],
                      low_bits_f(xfer_size, bus_size, addr[1:0],
                                 num_access_f(xfer_size, bus_size))};
      else if (smc_done && (r_num_access != 2'd0))
         smc_addr[1:0] <= low_bits_f(xfer_size, bus_size, r_addr,
                                     r_num_access - 2'd1);  // Next lower pair
   end

   // Internal byte enables, lanes follow the first address
   always_comb
   begin
      n_be = 4'b1111;
      if (v_cs)
      begin
         case ({xfer_size, bus_size})
            {XSIZ_8, BSIZ_8}:   n_be = 4'b1110;
            {XSIZ_8, BSIZ_16}:  n_be = v_addr[0] ? 4'b1101 : 4'b1110;
            {XSIZ_8, BSIZ_32}:  n_be = ~(4'b0001 << v_addr);    // One lane of four
            {XSIZ_16, BSIZ_8}:  n_be = 4'b1110;
            {XSIZ_16, BSIZ_16}: n_be = 4'b1100;
            {XSIZ_16, BSIZ_32}: n_be = v_addr[1] ? 4'b0011 : 4'b1100;
            {XSIZ_32, BSIZ_8}:  n_be = 4'b1110;
            {XSIZ_32, BSIZ_16}: n_be = 4'b1100;
            {XSIZ_32, BSIZ_32}: n_be = 4'b0000;
            default:            n_be = 4'b1111;        // Invalid size code
         endcase
      end
   end

   // Registered strobes, active only in SMC_RW
   always_ff @(posedge sys_clk28 or negedge n_sys_reset28)
   begin
      if (!n_sys_reset28)
      begin
         smc_n_cs <= 1'b1;
         smc_n_be <= 4'hF;
      end
      else if (smc_nextstate == SMC_RW)
      begin
         smc_n_cs <= ~v_cs;
         smc_n_be <= n_be;
      end
      else
      begin
         smc_n_cs <= 1'b1;
         smc_n_be <= 4'hF;
      end
   end

endmodule

/* source/smc_data_lane.sv */
// wdata and rdata use natural byte positions; bytes outside the transfer read back as zero
module smc_data_lane
   import smc_size_pkg::*;
(
   input  logic        sys_clk28,
   input  logic        n_sys_reset28,
   input  logic        valid_access,
   input  logic        capture,
   input  logic [1:0]  r_num_access,
   input  xfer_size_t  xfer_size,
   input  bus_size_t   bus_size,
   input  logic [1:0]  addr,
   input  logic [31:0] wdata,
   input  logic [31:0] smc_data_in,
   input  logic [3:0]  n_be,
   output logic [31:0] smc_data_out,
   output logic [31:0] rdata
);

   smc_word_u   wr_word;            // Host write data
   smc_word_u   lane_word;          // Write data moved to bus lanes
   smc_word_u   in_word;            // Enabled read lanes only
   smc_word_u   rd_word;            // Assembled host read word
   logic [31:0] lane_mask;
   logic [1:0]  byte_sel;           // Host byte on an 8-bit bus
   logic        half_sel;           // Host halfword on a 16-bit bus

   assign wr_word   = wdata;
   assign lane_mask = {{8{~n_be[3]}}, {8{~n_be[2]}}, {8{~n_be[1]}}, {8{~n_be[0]}}};
   assign in_word   = smc_data_in & lane_mask;

   // Which host slice the current access carries
   always_comb
   begin
      case (xfer_size)
         XSIZ_32:
         begin
            byte_sel = r_num_access;               // Counts 3 down to 0
            half_sel = r_num_access[0];
         end
         XSIZ_16:
         begin
            byte_sel = {addr[1], r_num_access[0]};
            half_sel = addr[1];
         end
         default:
         begin
            byte_sel = addr;
            half_sel = addr[1];
         end
      endcase
   end

   // ------------------------------
   // Write lane steering
   // ------------------------------
   always_comb
   begin
      lane_word = '0;
      case (bus_size)
         BSIZ_8:  lane_word.b[0] = wr_word.b[byte_sel];
         BSIZ_16: lane_word.h[0] = wr_word.h[half_sel];
         default: lane_word = wr_word;             // Already in place
      endcase
   end

   assign smc_data_out = lane_word & lane_mask;    // Disabled lanes driven low

   // ------------------------------
   // Read assembly
   // ------------------------------
   always_ff @(posedge sys_clk28 or negedge n_sys_reset28)
   begin
      if (!n_sys_reset28)
         rd_word <= '0;
      else if (valid_access)
         rd_word <= '0;                            // New transfer starts clean
      else if (capture)
      begin
         case (bus_size)
            BSIZ_8:  rd_word.b[byte_sel] <= in_word.b[0];
            BSIZ_16: rd_word.h[half_sel] <= in_word.h[0];
            default: rd_word <= in_word;
         endcase
      end
   end

   assign rdata = rd_word;          // Held through ack

endmodule

/* source/smc_size_pkg.sv */
// Little-endian ordering only; code 2'b11 is not a valid transfer or bus size
package smc_size_pkg;

   typedef logic [1:0] xfer_size_t;   // Host transfer size
   typedef logic [1:0] bus_size_t;    // External memory width

   localparam xfer_size_t XSIZ_8  = 2'b00;
   localparam xfer_size_t XSIZ_16 = 2'b01;
   localparam xfer_size_t XSIZ_32 = 2'b10;

   localparam bus_size_t BSIZ_8  = 2'b00;
   localparam bus_size_t BSIZ_16 = 2'b01;
   localparam bus_size_t BSIZ_32 = 2'b10;

   // Data word seen per byte lane or per halfword lane
   typedef union packed {
      logic [3:0][7:0]  b;          // Byte lanes, b[0] is bits 7:0
      logic [1:0][15:0] h;          // Halfword lanes, h[0] is bits 15:0
   } smc_word_u;

   // ------------------------------
   // Accesses needed, minus one
   // ------------------------------
   function automatic logic [1:0] num_access_f(xfer_size_t xs, bus_size_t bs);
      logic [1:0] n;
      n = 2'd0;                     // One access covers the rest
      case ({xs, bs})
         {XSIZ_32, BSIZ_8}:  n = 2'd3;   // Four byte accesses
         {XSIZ_32, BSIZ_16}: n = 2'd1;   // Two halfword accesses
         {XSIZ_16, BSIZ_8}:  n = 2'd1;   // Two byte accesses
         default:            n = 2'd0;
      endcase
      return n;
   endfunction

endpackage

/* source/smc_state_pkg.sv */
// Encoding is internal to the controller; only SMC_RW drives the memory strobes
package smc_state_pkg;

   // Controller states
   typedef enum logic [2:0] {
      SMC_IDLE  = 3'd0,             // Waiting for req
      SMC_LE    = 3'd1,             // Latch / setup, one cycle
      SMC_RW    = 3'd2,             // Strobes active, WAIT_STATES+1 cycles
      SMC_FLOAT = 3'd3,             // Bus turnaround between accesses
      SMC_ACK   = 3'd4              // Holding ack until req drops
   } smc_state_t;

endpackage

/* source/smc_top.sv */
// One chip select, little-endian; host follows the four-phase req/ack rule
module smc_top
   import smc_size_pkg::*;
   import smc_state_pkg::*;
#(
   parameter int WAIT_STATES = 1
)
(
   input  logic        sys_clk28,
   input  logic        n_sys_reset28,
   // Host side
   input  logic        req,
   input  logic        write,
   input  logic [31:0] addr,
   input  xfer_size_t  xfer_size,
   input  bus_size_t   bus_size,
   input  logic        cs,
   input  logic [31:0] wdata,
   output logic        ack,
   output logic [31:0] rdata,
   // Memory side
   output logic [31:0] smc_addr,
   output logic        smc_n_cs,
   output logic [3:0]  smc_n_be,
   output logic        smc_n_we,
   output logic [31:0] smc_data_out,
   input  logic [31:0] smc_data_in
);

   logic        valid_access;       // Pulse in SMC_LE
   logic        smc_done;           // Pulse per finished access
   logic        capture;            // Last SMC_RW cycle
   logic [1:0]  r_num_access;       // Accesses still to follow
   logic [3:0]  n_be;               // Unregistered byte enables
   smc_state_t  smc_nextstate;

   smc_access_fsm #(
      .WAIT_STATES (WAIT_STATES)
   ) u_fsm (
      .sys_clk28     (sys_clk28),
      .n_sys_reset28 (n_sys_reset28),
      .req           (req),
      .write         (write),
      .xfer_size     (xfer_size),
      .bus_size      (bus_size),
      .ack           (ack),
      .valid_access  (valid_access),
      .smc_done      (smc_done),
      .r_num_access  (r_num_access),
      .smc_nextstate (smc_nextstate),
      .smc_n_we      (smc_n_we),
      .capture       (capture)
   );

   smc_addr u_addr (
      .sys_clk28     (sys_clk28),
      .n_sys_reset28 (n_sys_reset28),
      .valid_access  (valid_access),
      .r_num_access  (r_num_access),
      .xfer_size     (xfer_size),
      .bus_size      (bus_size),
      .cs            (cs),
      .addr          (addr),
      .smc_done      (smc_done),
      .smc_nextstate (smc_nextstate),
      .smc_addr      (smc_addr),
      .smc_n_be      (smc_n_be),
      .smc_n_cs      (smc_n_cs),
      .n_be          (n_be)
   );

   // Lane choice follows the byte enables
   smc_data_lane u_data (
      .sys_clk28     (sys_clk28),
      .n_sys_reset28 (n_sys_reset28),
      .valid_access  (valid_access),
      .capture       (capture),
      .r_num_access  (r_num_access),
      .xfer_size     (xfer_size),
      .bus_size      (bus_size),
      .addr          (addr[1:0]),
      .wdata         (wdata),
      .smc_data_in   (smc_data_in),
      .n_be          (n_be),
      .smc_data_out  (smc_data_out),
      .rdata         (rdata)
   );

endmodule

/* tb.f */
source/smc_size_pkg.sv
source/smc_state_pkg.sv
source/smc_access_fsm.sv
source/smc_addr.sv
source/smc_data_lane.sv
source/smc_top.sv
verif/smc_sva.sv
verif/smc_tb.sv

/* verif/smc_sva.sv */
// Assumes cs, addr and sizes held stable by the host for a whole transfer; bound into smc_top
module smc_sva_checks
   import smc_size_pkg::*;
   import smc_state_pkg::*;
#(
   parameter int WAIT_STATES = 1
)
(
   input logic        sys_clk28,
   input logic        n_sys_reset28,
   input logic        req,
   input logic        write,
   input logic [31:0] addr,
   input xfer_size_t  xfer_size,
   input bus_size_t   bus_size,
   input logic        cs,
   input logic        ack,
   input logic [31:0] smc_addr,
   input logic        smc_n_cs,
   input logic [3:0]  smc_n_be,
   input logic        smc_n_we,
   input smc_state_t  smc_nextstate
);
   timeunit 1ns;
   timeprecision 100ps;

   int          fail_cnt = 0;       // Failed assertions so far
   logic        rw_q;               // High while the FSM sits in SMC_RW
   logic [1:0]  acc_idx;            // Access number within the transfer
   int          lat_cnt;            // Edges with req high and ack low
   int          n_acc;
   int          lat_exp;

   // Byte enables from access width and lowest lane
   function automatic logic [3:0] be_exp_f(xfer_size_t xs, bus_size_t bs, logic [1:0] a);
      int nb;                       // Bytes per access
      int lane;                     // Lowest enabled lane
      nb   = (xs < bs) ? (1 << xs) : (1 << bs);
      lane = int'(a) & ((1 << bs) - 1) & ~(nb - 1);
      return ~(4'((1 << nb) - 1) << lane);
   endfunction

   assign n_acc   = (xfer_size > bus_size) ? (1 << (xfer_size - bus_size)) : 1;
   assign lat_exp = 1 + n_acc * (WAIT_STATES + 2);

   // ------------------------------
   // Tracking state
   // ------------------------------
   always_ff @(posedge sys_clk28 or negedge n_sys_reset28)
   begin
      if (!n_sys_reset28)
      begin
         rw_q    <= 1'b0;
         acc_idx <= 2'd0;
         lat_cnt <= 0;
      end
      else
      begin
         rw_q <= (smc_nextstate == SMC_RW);
         if (ack)
            acc_idx <= 2'd0;
         else if (rw_q && (smc_nextstate != SMC_RW))
            acc_idx <= acc_idx + 2'd1;      // Access ends here
         if (!req)
            lat_cnt <= 0;
         else if (!ack)
            lat_cnt <= lat_cnt + 1;         // Also sees the edge that sets ack
      end
   end

   // ------------------------------
   // Assertions
   // ------------------------------
   a_reset: assert property (@(posedge sys_clk28)
      $rose(n_sys_reset28) |-> smc_n_cs && (smc_n_be == 4'hF) && smc_n_we && !ack
                               && (smc_addr == 32'h0))
   else
   begin
      $error("outputs not in reset state at reset release");
      fail_cnt++;
   end

   a_idle: assert property (@(posedge sys_clk28) disable iff (!n_sys_reset28)
      !rw_q |-> smc_n_cs && (smc_n_be == 4'hF) && smc_n_we)
   else
   begin
      $error("memory strobe active outside the access state");
      fail_cnt++;
   end

   a_strobe: assert property (@(posedge sys_clk28) disable iff (!n_sys_reset28)
      rw_q |-> (smc_n_cs == !cs) && (smc_n_we == !write))
   else
   begin
      $error("chip select or write strobe wrong during access");
      fail_cnt++;
   end

   a_be: assert property (@(posedge sys_clk28) disable iff (!n_sys_reset28)
      rw_q && cs |-> smc_n_be == be_exp_f(xfer_size, bus_size, addr[1:0]))
   else
   begin
      $error("byte enables do not match the size decode");
      fail_cnt++;
   end

   a_seq8: assert property (@(posedge sys_clk28) disable iff (!n_sys_reset28)
      rw_q && (xfer_size == XSIZ_32) && (bus_size == BSIZ_8)
      |-> smc_addr == {addr[31:2], 2'd3 - acc_idx})
   else
   begin
      $error("word on 8-bit bus has wrong address order");
      fail_cnt++;
   end

   a_seq16: assert property (@(posedge sys_clk28) disable iff (!n_sys_reset28)
      rw_q && (xfer_size == XSIZ_32) && (bus_size == BSIZ_16)
      |-> smc_addr == {addr[31:2], ~acc_idx[0], 1'b0})
   else
   begin
      $error("word on 16-bit bus has wrong address order");
      fail_cnt++;
   end

   a_latency: assert property (@(posedge sys_clk28) disable iff (!n_sys_reset28)
      $rose(ack) |-> lat_cnt == lat_exp + 1)
   else
   begin
      $error("ack rose at the wrong cycle");
      fail_cnt++;
   end

   a_hold: assert property (@(posedge sys_clk28) disable iff (!n_sys_reset28)
      ack && req |=> ack)
   else
   begin
      $error("ack dropped while req still held");
      fail_cnt++;
   end

   a_fall: assert property (@(posedge sys_clk28) disable iff (!n_sys_reset28)
      ack && !req |=> !ack)
   else
   begin
      $error("ack did not fall one cycle after req dropped");
      fail_cnt++;
   end

   // Idle and setup must come between handshake close and the next access
   a_gap: assert property (@(posedge sys_clk28) disable iff (!n_sys_reset28)
      $fell(ack) |-> !rw_q && (smc_nextstate != SMC_RW))
   else
   begin
      $error("new access started right after the handshake closed");
      fail_cnt++;
   end

endmodule

bind smc_top smc_sva_checks #(
   .WAIT_STATES (WAIT_STATES)
) u_sva (
   .sys_clk28     (sys_clk28),
   .n_sys_reset28 (n_sys_reset28),
   .req           (req),
   .write         (write),
   .addr          (addr),
   .xfer_size     (xfer_size),
   .bus_size      (bus_size),
   .cs            (cs),
   .ack           (ack),
   .smc_addr      (smc_addr),
   .smc_n_cs      (smc_n_cs),
   .smc_n_be      (smc_n_be),
   .smc_n_we      (smc_n_we),
   .smc_nextstate (smc_nextstate)
);

/* verif/smc_tb.sv */
// Memory model decodes only address bits 7:0; cs held high; needs a simulator with timing support
module smc_tb
   import smc_size_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_STATES = 1;
   localparam int CLK_PERIOD  = 20;
   localparam int HOLD_MAX    = 3;           // Longest back-pressure hold
   localparam int NUM_RANDOM  = 40;
   localparam int NUM_XFERS   = 72 + 16 + 9 + NUM_RANDOM;
   // Worst latency, hold and handshake margin per transfer
   localparam int XFER_CYCLES = 1 + 4 * (WAIT_STATES + 2) + HOLD_MAX + 6;
   localparam int TIMEOUT_CYCLES = 40 + NUM_XFERS * XFER_CYCLES;

   logic        sys_clk28;
   logic        n_sys_reset28;
   logic        req;
   logic        write;
   logic [31:0] addr;
   xfer_size_t  xfer_size;
   bus_size_t   bus_size;
   logic        cs;
   logic [31:0] wdata;
   logic        ack;
   logic [31:0] rdata;
   logic [31:0] smc_addr;
   logic        smc_n_cs;
   logic [3:0]  smc_n_be;
   logic        smc_n_we;
   logic [31:0] smc_data_out;
   logic [31:0] smc_data_in;

   logic [7:0]  mem [256];                   // External memory
   logic [7:0]  ref_mem [256];               // Expected memory contents
   string       test_name;
   int          seed;
   int          test_xfers;
   int          test_errors;
   int          sva_base;
   int          total_tests;
   int          total_xfers;
   int          total_errors;

   smc_top #(
      .WAIT_STATES (WAIT_STATES)
   ) uut (
      .sys_clk28     (sys_clk28),
      .n_sys_reset28 (n_sys_reset28),
      .req           (req),
      .write         (write),
      .addr          (addr),
      .xfer_size     (xfer_size),
      .bus_size      (bus_size),
      .cs            (cs),
      .wdata         (wdata),
      .ack           (ack),
      .rdata         (rdata),
      .smc_addr      (smc_addr),
      .smc_n_cs      (smc_n_cs),
      .smc_n_be      (smc_n_be),
      .smc_n_we      (smc_n_we),
      .smc_data_out  (smc_data_out),
      .smc_data_in   (smc_data_in)
   );

   // Start pattern, every address bit matters
   function automatic logic [7:0] fill_f(logic [7:0] a);
      return 8'(a * 8'd7) ^ 8'hA5;
   endfunction

   // Memory byte behind lane i for the current bus width
   function automatic logic [7:0] lane_addr_f(logic [31:0] sa, bus_size_t bs, int i);
      logic [7:0] la;
      case (bs)
         BSIZ_8:  la = sa[7:0];
         BSIZ_16: la = {sa[7:1], 1'b0} + 8'(i);
         default: la = {sa[7:2], 2'b00} + 8'(i);
      endcase
      return la;
   endfunction

   initial
   begin
      sys_clk28 = 1'b0;
      forever #(CLK_PERIOD / 2) sys_clk28 = ~sys_clk28;
   end

   // ------------------------------
   // Memory model
   // ------------------------------
   always @(posedge sys_clk28)
   begin
      if (!n_sys_reset28)
      begin
         for (int i = 0; i < 256; i++)
            mem[i] <= fill_f(8'(i));
      end
      else if (!smc_n_cs && !smc_n_we)
      begin
         for (int i = 0; i < 4; i++)
            if (!smc_n_be[i])
               mem[lane_addr_f(smc_addr, bus_size, i)] <= smc_data_out[8*i +: 8];
      end
   end

   always_comb
   begin
      for (int i = 0; i < 4; i++)
         smc_data_in[8*i +: 8] = mem[lane_addr_f(smc_addr, bus_size, i)];
   end

   // ------------------------------
   // Host transfer with checks
   // ------------------------------
   task automatic run_xfer(input logic wr, input logic [31:0] a, input xfer_size_t xs,
                           input bus_size_t bs, input logic [31:0] wd, input int hold);
      logic [31:0] exp;
      logic [7:0]  idx;
      exp = 32'h0;                           // Bytes outside the transfer read as zero
      @(posedge sys_clk28);
      req       <= 1'b1;
      write     <= wr;
      addr      <= a;
      xfer_size <= xs;
      bus_size  <= bs;
      wdata     <= wd;
      cs        <= 1'b1;
      // Bytes covered by the transfer, natural positions
      for (int j = 0; j < 4; j++)
      begin
         idx = {a[7:2], 2'(j)};
         if ((j >> xs) == (int'(a[1:0]) >> xs))
         begin
            if (wr)
               ref_mem[idx] = wd[8*j +: 8];
            else
               exp[8*j +: 8] = ref_mem[idx];
         end
      end
      while (!ack)
         @(posedge sys_clk28);
      if (!wr && (rdata !== exp))
      begin
         $display("CHECK FAILED %s addr %h expected %h actual %h", test_name, a, exp, rdata);
         test_errors++;
      end
      repeat (hold) @(posedge sys_clk28);    // Back-pressure
      req <= 1'b0;
      while (ack)
         @(posedge sys_clk28);
      test_xfers++;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_xfers  = 0;
      test_errors = 0;
      sva_base    = uut.u_sva.fail_cnt;
   endtask

   task automatic end_test();
      int sva_new;
      sva_new = uut.u_sva.fail_cnt - sva_base;
      $display("Test %s done: %0d transfers, %0d read errors, %0d assertion failures",
               test_name, test_xfers, test_errors, sva_new);
      total_tests++;
      total_xfers  += test_xfers;
      total_errors += test_errors;
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial
   begin
      logic [31:0] a;
      xfer_size_t  xs;
      bus_size_t   bs;
      seed          = 32'h43e1;
      n_sys_reset28 = 1'b0;
      req           = 1'b0;
      write         = 1'b0;
      addr          = 32'h0;
      xfer_size     = XSIZ_8;
      bus_size      = BSIZ_8;
      cs            = 1'b0;
      wdata         = 32'h0;
      total_tests   = 0;
      total_xfers   = 0;
      total_errors  = 0;
      for (int i = 0; i < 256; i++)
         ref_mem[i] = fill_f(8'(i));
      repeat (8) @(posedge sys_clk28);
      n_sys_reset28 <= 1'b1;

      start_test("reset_idle");
      repeat (4) @(posedge sys_clk28);
      end_test();

      start_test("be_decode");               // Every size pair and low address
      for (int b = 0; b < 3; b++)
         for (int x = 0; x < 3; x++)
            for (int l = 0; l < 4; l++)
            begin
               a = $random(seed);
               a[1:0] = 2'(l);
               run_xfer(1'b1, a, 2'(x), 2'(b), $random(seed), 0);
               run_xfer(1'b0, a, 2'(x), 2'(b), 32'h0, 0);
            end
      end_test();

      start_test("addr_seq");                // Words split over narrow buses
      for (int n = 0; n < 8; n++)
      begin
         a  = $random(seed);
         bs = (n < 4) ? BSIZ_8 : BSIZ_16;
         run_xfer(1'b1, a, XSIZ_32, bs, $random(seed), 0);
         run_xfer(1'b0, a, XSIZ_32, bs, 32'h0, 1);
      end
      end_test();

      start_test("handshake");               // Latency per pair and held req
      for (int b = 0; b < 3; b++)
         for (int x = 0; x < 3; x++)
            run_xfer(1'b0, $random(seed), 2'(x), 2'(b), 32'h0, (b + x) % (HOLD_MAX + 1));
      end_test();

      start_test("write_read");
      for (int n = 0; n < NUM_RANDOM; n++)
      begin
         a  = $random(seed) & 32'hFFFF_FF0F; // Small window so reads hit writes
         xs = 2'($unsigned($random(seed)) % 3);
         bs = 2'($unsigned($random(seed)) % 3);
         run_xfer(1'($random(seed)), a, xs, bs, $random(seed), 0);
      end
      end_test();

      repeat (3) @(posedge sys_clk28);
      $display("Totals: %0d tests, %0d transfers, %0d read errors, %0d assertion failures",
               total_tests, total_xfers, total_errors, uut.u_sva.fail_cnt);
      if ((total_errors == 0) && (uut.u_sva.fail_cnt == 0))
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout: transfers did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
   end

endmodule
